/* compile.f */
+incdir+hdl
hdl/silu_pkg.sv
hdl/lane_fifo.sv
hdl/lane_roller.sv
hdl/silu_lut.sv
hdl/fixed_silu.sv
sim/tb_fixed_silu.sv

/* Makefile */
SRCS := $(wildcard hdl/*.sv hdl/*.svh sim/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_fixed_silu: compile.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module tb_fixed_silu -f compile.f

run: obj_dir/Vtb_fixed_silu
	./obj_dir/Vtb_fixed_silu > sim.log 2>&1
	@cat sim.log
	@if grep -q "RESULT: FAIL" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

/* sim/silu_input.txt */
// columns: input lanes 0 to 3, then expected output lanes 0 to 3, all Q4.4 in hex.
// one record per line; records are streamed in file order.
80 90 A0 B0 00 00 00 FF
C0 D0 E0 F0 FF FE FC FC
00 10 20 30 00 0C 1C 2E
40 50 60 70 3F 4F 60 70
81 98 A1 AF 00 00 FF FF
B7 C4 D1 D8 FF FE FD FD
D9 DF E5 EC FC FC FC FC
F1 F4 F8 FF FC FD FE FF
01 04 08 0F 00 03 06 0B
13 1A 25 2B 0F 16 21 28
32 3E 47 4D 30 3C 46 4C
53 5F 66 6C 52 5E 66 6C
71 78 7C 7F 71 78 7C 7F
80 70 7F 80 00 70 7F 00
F6 F2 FC 0A FD FC FF 07
0C 18 2F 3A 09 14 2C 38
44 58 6F 74 43 57 6F 74
A8 C9 88 9F FF FE 00 00
BA E1 D4 DC FF FC FD FC
7F 80 00 FF 7F 00 00 FF
10 20 30 40 0C 1C 2E 3F
F8 F4 F1 F0 FE FD FC FC
25 13 01 70 21 0F 00 70
D8 D9 D1 DF FD FC FD FC
53 66 47 32 52 66 46 30
5F 6C 4D 3E 5E 6C 4C 3C
78 71 7C 50 78 71 7C 4F
04 08 0F 1A 03 06 0B 16
2B 60 C4 B7 28 60 FE FF
A1 AF 81 98 FF FF 00 00
E5 EC E0 D0 FC FC FC FE
90 A0 B0 C0 00 00 FF FF
0A 18 74 F6 07 14 74 FD
2F 44 DC 88 2C 43 FC 00
3A 58 BA 9F 38 57 FF 00
6F FC F2 0C 6F FF FC 09

/* sim/tb_fixed_silu.sv */
`timescale 1ns/1ps
`include "silu_config.svh"

module tb_fixed_silu;

  localparam int IN_LANES       = `SILU_IN_LANES;
  localparam int OUT_LANES      = `SILU_OUT_LANES;
  localparam int CHUNKS         = IN_LANES / OUT_LANES;
  localparam int NUM_RECORDS    = 36;
  localparam int REC_W          = 2 * IN_LANES;
  localparam int MEM_WORDS      = NUM_RECORDS * REC_W;
  localparam int TOTAL          = NUM_RECORDS * IN_LANES;
  localparam int RESET_CYCLES   = 8;
  localparam int START_STALL    = 10;
  localparam int DRAIN_CYCLES   = 10;
  localparam int TIMEOUT_CYCLES = 20 * NUM_RECORDS * CHUNKS + 100;
  localparam string DATA_FILE   = "sim/silu_input.txt";

  logic               clk;
  logic               arst_n;
  silu_pkg::in_vec_t  in_data;
  logic               in_valid;
  logic               in_ready;
  silu_pkg::out_vec_t out_data;
  logic               out_valid;
  logic               out_ready;

  logic [`SILU_DATA_W-1:0] vec_mem [MEM_WORDS];

  integer seed;
  int     value_errors;
  int     other_errors;
  int     out_count;
  int     cycles;
  bit     saw_full;

  fixed_silu DUT (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // returns output sample n in stream order from the expected columns of the file.
  function automatic logic [`SILU_DATA_W-1:0] expected_sample(input int n);
    return vec_mem[(n / IN_LANES) * REC_W + IN_LANES + (n % IN_LANES)];
  endfunction

  task automatic check_idle(input string phase);
    if (out_valid !== 1'b0) begin
      $display("error at %0t: out_valid is %b %s, expected 0.", $time, out_valid, phase);
      value_errors++;
    end
    if (in_ready !== 1'b1) begin
      $display("error at %0t: in_ready is %b %s, expected 1.", $time, in_ready, phase);
      value_errors++;
    end
  endtask

  // called on a rising edge; returns on the edge where the vector is taken.
  task automatic send_record(input int r);
    logic taken;
    for (int i = 0; i < IN_LANES; i++) begin
      in_data[i] <= vec_mem[r * REC_W + i];
    end
    in_valid <= 1'b1;
    do begin
      @(negedge clk);
      taken = in_ready;
      @(posedge clk);
    end while (!taken);
  endtask

  initial begin
    int fd;
    value_errors = 0;
    other_errors = 0;
    out_count    = 0;
    saw_full     = 1'b0;
    arst_n       = 1'b0;
    in_valid     = 1'b0;
    out_ready    = 1'b0;
    for (int i = 0; i < IN_LANES; i++) begin
      in_data[i] = '0;
    end

    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      $display("could not open the stimulus file %s.", DATA_FILE);
      other_errors++;
    end else begin
      $fclose(fd);
      $readmemh(DATA_FILE, vec_mem);
    end

    repeat (RESET_CYCLES) begin
      @(negedge clk);
      check_idle("during reset");
    end
    @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check_idle("after reset");
    @(posedge clk);

    for (int r = 0; r < NUM_RECORDS; r++) begin
      if (r % 7 == 6) begin
        in_valid <= 1'b0; // a short gap between bursts.
        repeat (3) @(posedge clk);
      end
      send_record(r);
    end
    in_valid <= 1'b0;

    wait (out_count >= TOTAL);
    repeat (DRAIN_CYCLES) @(posedge clk);

    if (!saw_full) begin
      $display("in_ready never went low while the input FIFO was full.");
      other_errors++;
    end
    $display("errors: %0d wrong values, %0d other failures; %0d of %0d samples received.",
             value_errors, other_errors, out_count, TOTAL);
    if (value_errors == 0 && other_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // the sink stalls at first so the FIFO fills, then toggles ready at random.
  initial begin
    logic [31:0] rnd;
    seed = 32'h9edf;
    wait (arst_n === 1'b1);
    repeat (START_STALL) @(posedge clk);
    forever begin
      rnd = $random(seed);
      out_ready <= rnd[0];
      @(posedge clk);
    end
  end

  // a high valid and ready seen mid-cycle means a transfer on the next edge.
  always @(negedge clk) begin
    logic [`SILU_DATA_W-1:0] exp_val;
    if (arst_n === 1'b1) begin
      if (in_valid && !in_ready) begin
        saw_full = 1'b1;
      end
      if (out_valid && out_ready) begin
        for (int j = 0; j < OUT_LANES; j++) begin
          if (out_count >= TOTAL) begin
            $display("an output beat carried a sample beyond the %0d expected ones.", TOTAL);
            other_errors++;
          end else begin
            exp_val = expected_sample(out_count);
            if (out_data[j] !== exp_val) begin
              $display("error at %0t: lane %0d, sample %0d, got %h, expected %h.",
                       $time, j, out_count, out_data[j], exp_val);
              value_errors++;
            end
          end
          out_count++;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: the output stream did not complete, %0d of %0d samples after %0d cycles.",
               out_count, TOTAL, cycles);
      $display("RESULT: FAIL");
      $finish;
    end
  end

endmodule

/* hdl/fixed_silu.sv */
`timescale 1ns/1ps
`include "silu_config.svh"

module fixed_silu (
  input  logic               clk,
  input  logic               arst_n,
  input  silu_pkg::in_vec_t  in_data,
  input  logic               in_valid,
  output logic               in_ready,
  output silu_pkg::out_vec_t out_data,
  output logic               out_valid,
  input  logic               out_ready
);

  silu_pkg::in_vec_t  fifo_data;
  logic               fifo_valid;
  logic               fifo_ready;

  silu_pkg::out_vec_t roll_data;
  logic               roll_valid;
  logic               roll_ready;

  lane_fifo input_fifo (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_data  (fifo_data),
    .out_valid (fifo_valid),
    .out_ready (fifo_ready)
  );

  lane_roller roller (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_data   (fifo_data),
    .in_valid  (fifo_valid),
    .in_ready  (fifo_ready),
    .out_data  (roll_data),
    .out_valid (roll_valid),
    .out_ready (roll_ready)
  );

  // the activation is combinational, so the roller's handshake is the output one.
  for (genvar i = 0; i < `SILU_OUT_LANES; i++) begin : g_lane
    silu_lut silu_map (
      .x (roll_data[i]),
      .y (out_data[i])
    );
  end

  assign out_valid  = roll_valid;
  assign roll_ready = out_ready;

endmodule

/* hdl/silu_lut.sv */
`timescale 1ns/1ps
`include "silu_config.svh"

module silu_lut (
  input  silu_pkg::sample_t x,
  output silu_pkg::sample_t y
);

  localparam int W     = `SILU_DATA_W;
  localparam int FW    = `SILU_FRAC_W;
  localparam int IW    = W - FW;
  localparam int N_PTS = 1 << IW;
  localparam logic [IW-1:0] LAST_IDX = {IW{1'b1}};

  // SiLU at the integers -8 to 7 in Q4.4, stored at index k + 8.
  localparam silu_pkg::sample_t T [N_PTS] = '{
    8'sd0,
    8'sd0,
    8'sd0,
    -8'sd1,
    -8'sd1,
    -8'sd2,
    -8'sd4,
    -8'sd4,
    8'sd0,
    8'sd12,
    8'sd28,
    8'sd46,
    8'sd63,
    8'sd79,
    8'sd96,
    8'sd112
  };

  logic [IW-1:0]         idx;
  logic [IW-1:0]         idx_hi;
  logic [FW-1:0]         frac;
  silu_pkg::sample_t     t_lo;
  silu_pkg::sample_t     t_hi;
  logic signed [W:0]     slope;
  logic signed [W+FW+1:0] prod;
  logic signed [W+1:0]   step;
  logic signed [W+1:0]   base;
  logic signed [W+1:0]   sum;

  assign idx    = {~x[W-1], x[W-2:FW]}; // offset binary of the integer part.
  assign idx_hi = idx + 1'b1; // wraps at the top, where it is not used.
  assign frac   = x[FW-1:0];

  assign t_lo = T[idx];
  assign t_hi = T[idx_hi];

  assign slope = {t_hi[W-1], t_hi} - {t_lo[W-1], t_lo};
  assign prod  = slope * $signed({1'b0, frac});
  assign step  = prod[W+FW+1:FW]; // arithmetic shift right by the fraction width.
  assign base  = {{2{t_lo[W-1]}}, t_lo};

  always_comb begin
    if (idx == LAST_IDX) begin
      sum = base + {{(W+2-FW){1'b0}}, frac}; // slope of one past the last point.
    end else begin
      sum = base + step;
    end
  end

  assign y = sum[W-1:0];

endmodule

/* hdl/lane_roller.sv */
`timescale 1ns/1ps
`include "silu_config.svh"

module lane_roller (
  input  logic               clk,
  input  logic               arst_n,
  input  silu_pkg::in_vec_t  in_data,
  input  logic               in_valid,
  output logic               in_ready,
  output silu_pkg::out_vec_t out_data,
  output logic               out_valid,
  input  logic               out_ready
);

  localparam int IN_LANES  = `SILU_IN_LANES;
  localparam int OUT_LANES = `SILU_OUT_LANES;
  localparam int N_CHUNKS  = IN_LANES / OUT_LANES;
  localparam int SAMPLE_W  = `SILU_DATA_W;
  localparam int FLAT_W    = OUT_LANES * SAMPLE_W;

  silu_pkg::in_vec_t held;

  logic              full;
  logic              in_fire;
  logic              out_fire;
  logic [FLAT_W-1:0] out_flat;

  assign out_valid = full;
  assign in_fire   = in_valid && in_ready;
  assign out_fire  = full && out_ready;

  if ((IN_LANES % OUT_LANES) != 0) begin : g_ratio_check
    $error("lane_roller needs OUT_LANES to divide IN_LANES.");
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      held <= in_data;
    end
  end

  if (N_CHUNKS == 1) begin : g_slice
    // equal widths, so the roller is a one-entry register slice.
    assign in_ready = !full || out_ready;

    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        full <= 1'b0;
      end else if (in_fire) begin
        full <= 1'b1;
      end else if (out_fire) begin
        full <= 1'b0;
      end
    end

    always_comb begin
      for (int j = 0; j < OUT_LANES; j++) begin
        out_data[j] = held[j];
      end
    end
  end else begin : g_roll
    localparam int IDX_W  = $clog2(N_CHUNKS);
    localparam int LANE_W = $clog2(IN_LANES);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(N_CHUNKS - 1);

    logic [IDX_W-1:0] idx;
    logic             last;

    assign last     = (idx == LAST_IDX);
    assign in_ready = !full || (out_ready && last); // refill only as the last chunk leaves.

    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        full <= 1'b0;
        idx  <= '0;
      end else if (in_fire) begin
        full <= 1'b1;
        idx  <= '0;
      end else if (out_fire) begin
        if (last) begin
          full <= 1'b0;
        end else begin
          idx <= idx + 1'b1;
        end
      end
    end

    always_comb begin
      for (int j = 0; j < OUT_LANES; j++) begin
        out_data[j] = held[LANE_W'(int'(idx) * OUT_LANES + j)];
      end
    end
  end

  always_comb begin
    for (int j = 0; j < OUT_LANES; j++) begin
      out_flat[j*SAMPLE_W +: SAMPLE_W] = out_data[j];
    end
  end

  a_out_stable: assert property (
    @(posedge clk) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_flat)
  ) else $error("lane_roller output changed while stalled.");

endmodule

/* hdl/lane_fifo.sv */
`timescale 1ns/1ps
`include "silu_config.svh"

module lane_fifo (
  input  logic              clk,
  input  logic              arst_n,
  input  silu_pkg::in_vec_t in_data,
  input  logic              in_valid,
  output logic              in_ready,
  output silu_pkg::in_vec_t out_data,
  output logic              out_valid,
  input  logic              out_ready
);

  localparam int DEPTH = `SILU_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int SAMPLE_W = `SILU_DATA_W;
  localparam int FLAT_W = `SILU_IN_LANES * SAMPLE_W;
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

  silu_pkg::in_vec_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             wr_en;
  logic             rd_en;
  logic [FLAT_W-1:0] out_flat;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (ptr == LAST_PTR) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  assign in_ready  = (count != FULL_CNT);
  assign out_valid = (count != '0);
  assign wr_en     = in_valid && in_ready;
  assign rd_en     = out_valid && out_ready;
  assign out_data  = mem[rd_ptr]; // head entry falls through to the output.

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (rd_en) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      if (wr_en && !rd_en) begin
        count <= count + 1'b1;
      end else if (rd_en && !wr_en) begin
        count <= count - 1'b1;
      end
    end
  end

  // packed copy of the head entry for the stability check.
  always_comb begin
    for (int i = 0; i < `SILU_IN_LANES; i++) begin
      out_flat[i*SAMPLE_W +: SAMPLE_W] = out_data[i];
    end
  end

  a_count_bound: assert property (
    @(posedge clk) disable iff (!arst_n)
    count <= FULL_CNT
  ) else $error("lane_fifo occupancy exceeds its depth.");

  a_head_stable: assert property (
    @(posedge clk) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_flat)
  ) else $error("lane_fifo head changed while stalled.");

endmodule

/* hdl/silu_pkg.sv */
`include "silu_config.svh"

package silu_pkg;

  // one signed fixed-point sample with SILU_FRAC_W fraction bits.
  typedef logic signed [`SILU_DATA_W-1:0] sample_t;

  // the vector that arrives on one input beat.
  typedef sample_t in_vec_t [`SILU_IN_LANES];

  // the vector that leaves on one output beat.
  typedef sample_t out_vec_t [`SILU_OUT_LANES];

endpackage

/* hdl/silu_config.svh */
`ifndef SILU_CONFIG_SVH
`define SILU_CONFIG_SVH

// sample width in bits.
`define SILU_DATA_W 8

// fractional bits of the signed sample, giving Q4.4 with the width above.
`define SILU_FRAC_W 4

// samples carried by one input beat.
`define SILU_IN_LANES 4

// samples carried by one output beat; it has to divide SILU_IN_LANES.
`define SILU_OUT_LANES 2

// entries in the input vector FIFO.
`define SILU_FIFO_DEPTH 4

`endif
